// File: design/isa_pkg.sv
package isa_pkg;

	parameter int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0]      reg_addr_t;
	typedef logic [2:0]      funct3_t;

	// Major opcodes, bits [6:0] of the instruction
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111
	} opcode_e;

	// Register and immediate arithmetic
	localparam funct3_t F3_ADD_SUB = 3'b000;
	localparam funct3_t F3_SLL     = 3'b001;
	localparam funct3_t F3_SLT     = 3'b010;
	localparam funct3_t F3_SLTU    = 3'b011;
	localparam funct3_t F3_XOR     = 3'b100;
	localparam funct3_t F3_SR      = 3'b101; // SRL or SRA by bit 30
	localparam funct3_t F3_OR      = 3'b110;
	localparam funct3_t F3_AND     = 3'b111;

	// Conditional branches
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

endpackage

// File: design/core_pkg.sv
package core_pkg;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_XOR, ALU_OR, ALU_AND
	} alu_op_e;

	typedef enum logic [1:0] {
		CMP_EQ, CMP_LT, CMP_LTU
	} cmp_op_e;

	// One instruction in flight at a time
	typedef enum logic [2:0] {
		FETCH, DECODE, EXECUTE, MEMR, MEMW
	} state_e;

	// UPPER is LUI and AUIPC
	typedef enum logic [2:0] {
		CLS_ARITH, CLS_SETLESS, CLS_LOAD, CLS_STORE, CLS_BRANCH, CLS_JUMP, CLS_UPPER
	} op_class_e;

endpackage

// File: design/core_ifs.sv
`timescale 1ns/1ps

// Decoded operation, registered at the end of DECODE
interface dec_if;
	import isa_pkg::*;
	import core_pkg::*;

	op_class_e op_class;
	alu_op_e   alu_op;
	cmp_op_e   cmp_op;
	logic      cmp_invert; // BNE, BGE, BGEU
	word_t     opnd_a;
	word_t     opnd_b;
	word_t     cmp_b;      // rs2 or immediate
	word_t     rs1_data;
	word_t     store_data;
	reg_addr_t rd;

	modport decoder (output op_class, alu_op, cmp_op, cmp_invert, opnd_a, opnd_b,
		cmp_b, rs1_data, store_data, rd);
	modport executor (input op_class, alu_op, cmp_op, cmp_invert, opnd_a, opnd_b,
		cmp_b, rs1_data, store_data);
	modport sequencer (input op_class, rd);
endinterface

interface exe_if;
	import isa_pkg::*;

	word_t result;
	word_t target;
	logic  taken;
	word_t mem_addr;
	word_t store_data;

	modport producer (output result, target, taken, mem_addr, store_data);
	modport consumer (input result, target, taken, mem_addr, store_data);
endinterface

// File: design/core_regfile.sv
`timescale 1ns/1ps

module core_regfile (
	input  logic               clock,
	input  logic               reset,
	input  isa_pkg::reg_addr_t rs1,
	input  isa_pkg::reg_addr_t rs2,
	output isa_pkg::word_t     rs1_data,
	output isa_pkg::word_t     rs2_data,
	input  logic               wr_en,
	input  isa_pkg::reg_addr_t wr_addr,
	input  isa_pkg::word_t     wr_data
);
	import isa_pkg::*;

	word_t regs [31:1]; // x0 has no storage

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];
endmodule

// File: design/core_decode.sv
`timescale 1ns/1ps

module core_decode (
	input  logic               clock,
	input  logic               reset,
	input  logic               fetch_done,
	input  isa_pkg::word_t     idata,
	input  isa_pkg::word_t     pc,
	output isa_pkg::reg_addr_t rs1,
	output isa_pkg::reg_addr_t rs2,
	input  isa_pkg::word_t     rs1_data,
	input  isa_pkg::word_t     rs2_data,
	dec_if.decoder             dec
);
	import isa_pkg::*;
	import core_pkg::*;

	word_t     instr_q;
	logic      decode_cycle; // Cycle after the fetch transfer
	opcode_e   opcode;
	funct3_t   funct3;
	word_t     imm_i, imm_s, imm_b, imm_u, imm_j;
	op_class_e cls_n;
	alu_op_e   alu_n;
	cmp_op_e   cmp_n;
	logic      inv_n;
	word_t     a_n, b_n, cmpb_n;
	reg_addr_t rd_n;

	function automatic alu_op_e alu_sel(input funct3_t f3, input logic alt);
		case (f3)
			F3_ADD_SUB: alu_sel = alt ? ALU_SUB : ALU_ADD;
			F3_SLL:     alu_sel = ALU_SLL;
			F3_XOR:     alu_sel = ALU_XOR;
			F3_SR:      alu_sel = alt ? ALU_SRA : ALU_SRL;
			F3_OR:      alu_sel = ALU_OR;
			F3_AND:     alu_sel = ALU_AND;
			default:    alu_sel = ALU_ADD; // SLT and SLTU go to the comparator
		endcase
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			decode_cycle <= 1'b0;
		end else begin
			decode_cycle <= fetch_done;
		end
	end

	always_ff @(posedge clock) begin
		if (fetch_done) begin
			instr_q <= idata;
		end
	end

	assign opcode = opcode_e'(instr_q[6:0]);
	assign funct3 = instr_q[14:12];
	assign rs1    = instr_q[19:15];
	assign rs2    = instr_q[24:20];

	assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
	assign imm_s = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
	assign imm_b = {{20{instr_q[31]}}, instr_q[7], instr_q[30:25], instr_q[11:8], 1'b0};
	assign imm_u = {instr_q[31:12], 12'h000};
	assign imm_j = {{12{instr_q[31]}}, instr_q[19:12], instr_q[20], instr_q[30:21], 1'b0};

	always_comb begin
		cls_n  = CLS_ARITH;
		alu_n  = ALU_ADD;
		cmp_n  = CMP_EQ;
		inv_n  = 1'b0;
		a_n    = rs1_data;
		b_n    = imm_i;
		cmpb_n = rs2_data;
		rd_n   = instr_q[11:7];
		case (opcode)
			OPC_OP, OPC_OP_IMM: begin
				if (opcode == OPC_OP) begin
					b_n   = rs2_data;
					alu_n = alu_sel(funct3, instr_q[30]);
				end else begin
					cmpb_n = imm_i;
					alu_n  = alu_sel(funct3, instr_q[30] && funct3 == F3_SR); // No SUBI
					if (funct3 == F3_SLL || funct3 == F3_SR) begin
						b_n = {27'b0, imm_i[4:0]}; // shamt
					end
				end
				if (funct3 == F3_SLT || funct3 == F3_SLTU) begin
					cls_n = CLS_SETLESS;
					cmp_n = (funct3 == F3_SLT) ? CMP_LT : CMP_LTU;
				end
			end
			OPC_LOAD:  cls_n = CLS_LOAD;
			OPC_STORE: begin
				cls_n = CLS_STORE;
				b_n   = imm_s;
			end
			OPC_BRANCH: begin
				cls_n = CLS_BRANCH;
				a_n   = pc;
				b_n   = imm_b;
				inv_n = funct3[0];
				case (funct3[2:1])
					2'b00:   cmp_n = CMP_EQ;
					2'b10:   cmp_n = CMP_LT;
					default: cmp_n = CMP_LTU;
				endcase
			end
			OPC_JAL: begin
				cls_n = CLS_JUMP;
				a_n   = pc;
				b_n   = imm_j;
			end
			OPC_JALR:  cls_n = CLS_JUMP;
			OPC_LUI: begin
				cls_n = CLS_UPPER;
				a_n   = imm_u;
				b_n   = '0;
			end
			OPC_AUIPC: begin
				cls_n = CLS_UPPER;
				a_n   = pc;
				b_n   = imm_u;
			end
			default: rd_n = '0; // Unknown opcode acts as a NOP
		endcase
	end

	always_ff @(posedge clock) begin
		if (decode_cycle) begin
			dec.op_class   <= cls_n;
			dec.alu_op     <= alu_n;
			dec.cmp_op     <= cmp_n;
			dec.cmp_invert <= inv_n;
			dec.opnd_a     <= a_n;
			dec.opnd_b     <= b_n;
			dec.cmp_b      <= cmpb_n;
			dec.rs1_data   <= rs1_data;
			dec.store_data <= rs2_data;
			dec.rd         <= rd_n;
		end
	end
endmodule

// File: design/core_execute.sv
`timescale 1ns/1ps

module core_execute (
	dec_if.executor dec,
	exe_if.producer exe
);
	import isa_pkg::*;
	import core_pkg::*;

	word_t alu_out;
	logic  cmp_out;
	logic  cond;

	always_comb begin
		case (dec.alu_op)
			ALU_ADD: alu_out = dec.opnd_a + dec.opnd_b;
			ALU_SUB: alu_out = dec.opnd_a - dec.opnd_b;
			ALU_SLL: alu_out = dec.opnd_a << dec.opnd_b[4:0];
			ALU_SRL: alu_out = dec.opnd_a >> dec.opnd_b[4:0];
			ALU_SRA: alu_out = word_t'($signed(dec.opnd_a) >>> dec.opnd_b[4:0]);
			ALU_XOR: alu_out = dec.opnd_a ^ dec.opnd_b;
			ALU_OR:  alu_out = dec.opnd_a | dec.opnd_b;
			default: alu_out = dec.opnd_a & dec.opnd_b;
		endcase
	end

	always_comb begin
		case (dec.cmp_op)
			CMP_EQ:  cmp_out = (dec.rs1_data == dec.cmp_b);
			CMP_LT:  cmp_out = ($signed(dec.rs1_data) < $signed(dec.cmp_b));
			CMP_LTU: cmp_out = (dec.rs1_data < dec.cmp_b);
			default: cmp_out = 1'b0;
		endcase
	end

	assign cond = cmp_out ^ dec.cmp_invert;

	assign exe.result = (dec.op_class == CLS_SETLESS) ? {{(XLEN-1){1'b0}}, cond} : alu_out;

	// Word aligned so JALR drops its low bits here
	assign exe.target   = {alu_out[XLEN-1:2], 2'b00};
	assign exe.mem_addr = {alu_out[XLEN-1:2], 2'b00};

	assign exe.taken = (dec.op_class == CLS_JUMP) ||
		(dec.op_class == CLS_BRANCH && cond);
	assign exe.store_data = dec.store_data;
endmodule

// File: design/core_sequencer.sv
`timescale 1ns/1ps

module core_sequencer #(
	parameter isa_pkg::word_t RESET_VECTOR = 32'h8000_0000
) (
	input  logic               clock,
	input  logic               reset,
	dec_if.sequencer           dec,
	exe_if.consumer            exe,
	output isa_pkg::word_t     iaddr,
	output logic               ivalid,
	input  logic               iready,
	output isa_pkg::word_t     daddr,
	output isa_pkg::word_t     dwdata,
	input  isa_pkg::word_t     drdata,
	output logic               dwrite,
	output logic               dvalid,
	input  logic               dready,
	output logic               fetch_done,
	output isa_pkg::word_t     pc,
	output logic               wr_en,
	output isa_pkg::reg_addr_t wr_addr,
	output isa_pkg::word_t     wr_data
);
	import isa_pkg::*;
	import core_pkg::*;

	state_e state;
	word_t  pc_plus4;
	word_t  pc_next;
	logic   data_done;

	assign pc_plus4 = pc + 32'd4;
	assign pc_next  = exe.taken ? exe.target : pc_plus4;

	assign iaddr      = pc;
	assign ivalid     = (state == FETCH);
	assign fetch_done = ivalid && iready;

	// Bundle and pc are held, so address and data stay stable until dready
	assign dvalid    = (state == MEMR || state == MEMW);
	assign dwrite    = (state == MEMW);
	assign daddr     = exe.mem_addr;
	assign dwdata    = exe.store_data;
	assign data_done = dvalid && dready;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= FETCH;
			pc    <= RESET_VECTOR;
		end else begin
			case (state)
				FETCH:   if (fetch_done) state <= DECODE;
				DECODE:  state <= EXECUTE;
				EXECUTE: begin
					if (dec.op_class == CLS_LOAD) begin
						state <= MEMR;
					end else if (dec.op_class == CLS_STORE) begin
						state <= MEMW;
					end else begin
						pc    <= pc_next;
						state <= FETCH;
					end
				end
				MEMR, MEMW: begin
					if (data_done) begin
						pc    <= pc_next; // Never taken here
						state <= FETCH;
					end
				end
				default: state <= FETCH;
			endcase
		end
	end

	always_comb begin
		wr_en = 1'b0;
		if (dec.rd != '0) begin
			if (state == EXECUTE) begin
				wr_en = !(dec.op_class inside {CLS_STORE, CLS_BRANCH, CLS_LOAD});
			end else if (state == MEMR) begin
				wr_en = dready; // Load data transfer
			end
		end
	end

	assign wr_addr = dec.rd;
	assign wr_data = (dec.op_class == CLS_JUMP) ? pc_plus4 :
		(dec.op_class == CLS_LOAD) ? drdata : exe.result;
endmodule

// File: design/core_top.sv
`timescale 1ns/1ps

module core_top #(
	parameter isa_pkg::word_t RESET_VECTOR = 32'h8000_0000
) (
	input  logic           clock,
	input  logic           reset,
	output isa_pkg::word_t iaddr,
	input  isa_pkg::word_t idata,
	output logic           ivalid,
	input  logic           iready,
	output isa_pkg::word_t daddr,
	output isa_pkg::word_t dwdata,
	input  isa_pkg::word_t drdata,
	output logic           dwrite,
	output logic           dvalid,
	input  logic           dready
);
	import isa_pkg::*;

	reg_addr_t rs1, rs2;
	word_t     rs1_data, rs2_data;
	logic      fetch_done;
	word_t     pc;
	logic      wr_en;
	reg_addr_t wr_addr;
	word_t     wr_data;

	dec_if dec_bus ();
	exe_if exe_bus ();

	core_regfile u_regfile (
		.clock, .reset, .rs1, .rs2, .rs1_data, .rs2_data, .wr_en, .wr_addr, .wr_data
	);

	core_decode u_decode (
		.clock, .reset, .fetch_done, .idata, .pc, .rs1, .rs2, .rs1_data, .rs2_data,
		.dec (dec_bus.decoder)
	);

	core_execute u_execute (.dec (dec_bus.executor), .exe (exe_bus.producer));

	core_sequencer #(.RESET_VECTOR (RESET_VECTOR)) u_sequencer (
		.clock, .reset, .dec (dec_bus.sequencer), .exe (exe_bus.consumer),
		.iaddr, .ivalid, .iready, .daddr, .dwdata, .drdata, .dwrite, .dvalid, .dready,
		.fetch_done, .pc, .wr_en, .wr_addr, .wr_data
	);
endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clock,
	output logic reset
);
	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock; // 10 ns period
	end

	// Reset covers the first four rising edges
	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end
endmodule

// File: testbench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
	parameter isa_pkg::word_t RESET_VECTOR = 32'h8000_0000
) (
	input  logic           clock,
	input  logic           reset,
	input  isa_pkg::word_t iaddr,
	input  isa_pkg::word_t idata,
	input  logic           ivalid,
	input  logic           iready,
	input  isa_pkg::word_t daddr,
	input  isa_pkg::word_t dwdata,
	input  isa_pkg::word_t drdata,
	input  logic           dwrite,
	input  logic           dvalid,
	input  logic           dready,
	output bit             done,
	output int             checks,
	output int             errors
);
	import isa_pkg::*;

	word_t     regs [32];
	word_t     pc;
	logic      mem_due; // A data transfer is owed
	logic      exp_write;
	word_t     exp_addr;
	word_t     exp_wdata;
	reg_addr_t load_rd;
	int        loops;

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	// Instruction-set model of one instruction
	function automatic void step_model(input word_t instr);
		word_t a;
		word_t b;
		word_t res;
		word_t next_pc;
		logic  take;
		logic  wr;
		a = regs[instr[19:15]];
		b = regs[instr[24:20]];
		res = pc + 32'd4; // Link value for jumps
		next_pc = pc + 32'd4;
		take = 1'b0;
		wr = 1'b1;
		case (instr[6:0])
			OPC_OP, OPC_OP_IMM: begin
				if (instr[6:0] == OPC_OP_IMM) begin
					b = {{20{instr[31]}}, instr[31:20]};
				end
				case (instr[14:12])
					F3_ADD_SUB: res = (instr[6:0] == OPC_OP && instr[30]) ? a - b : a + b;
					F3_SLL:     res = a << b[4:0];
					F3_SLT:     res = {31'b0, $signed(a) < $signed(b)};
					F3_SLTU:    res = {31'b0, a < b};
					F3_XOR:     res = a ^ b;
					F3_SR:      res = instr[30] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
					F3_OR:      res = a | b;
					default:    res = a & b;
				endcase
			end
			OPC_LUI:   res = {instr[31:12], 12'h000};
			OPC_AUIPC: res = pc + {instr[31:12], 12'h000};
			OPC_JAL: begin
				next_pc = pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			end
			OPC_JALR: next_pc = a + {{20{instr[31]}}, instr[31:20]};
			OPC_BRANCH: begin
				wr = 1'b0;
				case (instr[14:12])
					F3_BEQ:  take = (a == b);
					F3_BNE:  take = (a != b);
					F3_BLT:  take = ($signed(a) < $signed(b));
					F3_BGE:  take = ($signed(a) >= $signed(b));
					F3_BLTU: take = (a < b);
					F3_BGEU: take = (a >= b);
					default: take = 1'b0;
				endcase
				if (take) begin
					next_pc = pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
				end
			end
			OPC_LOAD, OPC_STORE: begin
				wr = 1'b0;
				mem_due = 1'b1;
				exp_write = instr[5]; // Set for stores only
				if (instr[5]) begin
					exp_addr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
				end else begin
					exp_addr = a + {{20{instr[31]}}, instr[31:20]};
				end
				exp_addr[1:0] = 2'b00;
				exp_wdata = b;
				load_rd = instr[11:7];
			end
			default: wr = 1'b0;
		endcase
		if (wr && instr[11:7] != 5'd0) begin
			regs[instr[11:7]] = res;
		end
		pc = {next_pc[31:2], 2'b00}; // Word aligned target
	endfunction

	always @(posedge clock) begin
		if (reset) begin
			foreach (regs[r])
				regs[r] = '0;
			pc = RESET_VECTOR;
			mem_due = 1'b0;
			loops = 0;
			done = 1'b0;
			checks = 0;
			errors = 0;
		end else begin
			if (ivalid && iready) begin
				check_value("iaddr", pc, iaddr);
				if (mem_due) begin
					errors++;
					$display("Error at %0t: a fetch came before the owed data transfer", $time);
				end
				if (idata == 32'h0000_006f) begin
					loops++;
					done = (loops >= 2); // Program parked in its final loop
				end
				step_model(idata);
			end
			if (dvalid && dready) begin
				if (!mem_due) begin
					errors++;
					$display("Error at %0t: data transfer without a pending load or store", $time);
				end else begin
					check_value("daddr", exp_addr, daddr);
					check_value("dwrite", word_t'(exp_write), word_t'(dwrite));
					if (exp_write) begin
						check_value("dwdata", exp_wdata, dwdata);
					end else if (load_rd != 5'd0) begin
						regs[load_rd] = drdata; // Load data as seen on the bus
					end
					mem_due = 1'b0;
				end
			end
		end
	end
endmodule

// File: testbench/core_asserts.sv
`timescale 1ns/1ps

module core_asserts (
	input logic           clock,
	input logic           reset,
	input isa_pkg::word_t iaddr,
	input isa_pkg::word_t idata,
	input logic           ivalid,
	input logic           iready,
	input isa_pkg::word_t daddr,
	input isa_pkg::word_t dwdata,
	input logic           dwrite,
	input logic           dvalid,
	input logic           dready
);
	import isa_pkg::*;

	int   failures = 0; // Summed into the closing report
	logic mem_op;

	assign mem_op = idata[6:0] inside {OPC_LOAD, OPC_STORE};

	a_reset_state: assert property (@(posedge clock) $fell(reset) |-> ivalid && !dvalid && !dwrite)
		else begin
			failures++;
			$error("Bus state after reset is wrong");
		end

	a_buses_exclusive: assert property (@(posedge clock) disable iff (reset) !(ivalid && dvalid))
		else begin
			failures++;
			$error("ivalid and dvalid are high together");
		end

	a_fetch_hold: assert property (@(posedge clock) disable iff (reset)
		ivalid && !iready |=> ivalid && $stable(iaddr))
		else begin
			failures++;
			$error("Fetch request changed before iready");
		end

	a_data_hold: assert property (@(posedge clock) disable iff (reset)
		dvalid && !dready |=> dvalid && $stable(daddr) && $stable(dwdata) && $stable(dwrite))
		else begin
			failures++;
			$error("Data request changed before dready");
		end

	a_write_valid: assert property (@(posedge clock) disable iff (reset) dwrite |-> dvalid)
		else begin
			failures++;
			$error("dwrite is high without dvalid");
		end

	// DECODE, EXECUTE, then FETCH again
	a_fetch_gap: assert property (@(posedge clock) disable iff (reset)
		ivalid && iready && !mem_op |=> !ivalid ##1 !ivalid ##1 ivalid)
		else begin
			failures++;
			$error("Next fetch did not follow three cycles after a non-memory instruction");
		end
endmodule

bind core_top core_asserts u_asserts (.*);

// File: testbench/tb_top.sv
`timescale 1ns/1ps

module tb_top;
	import isa_pkg::*;

	localparam word_t RESET_VECTOR = 32'h8000_0000;
	localparam int    PROG_WORDS   = 160;
	localparam int    BODY_WORDS   = 128; // Then 31 stores and the final loop
	localparam int    TIMEOUT_NS   = PROG_WORDS * 10 * 10 * 2;

	logic  clock;
	logic  reset;
	word_t iaddr;
	word_t idata;
	logic  ivalid;
	logic  iready;
	word_t daddr;
	word_t dwdata;
	word_t drdata;
	logic  dwrite;
	logic  dvalid;
	logic  dready;
	bit    done;
	int    checks;
	int    errors;

	word_t prog [PROG_WORDS];
	word_t dmem [64]; // Data window at byte addresses 0 to 252

	function automatic word_t enc_r(input int f7, input int rs2, input int rs1, input int f3,
		input int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
	endfunction

	function automatic word_t enc_i(input int imm, input int rs1, input int f3, input int rd,
		input logic [6:0] opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
	endfunction

	function automatic word_t enc_s(input int imm, input int rs2, input int rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
	endfunction

	function automatic word_t enc_b(input int imm, input int rs2, input int rs1, input int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic word_t enc_u(input int imm, input int rd, input logic [6:0] opc);
		return {imm[19:0], rd[4:0], opc};
	endfunction

	function automatic word_t enc_j(input int imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
	endfunction

	function automatic word_t fetch_word(input word_t addr);
		word_t offset;
		offset = addr - RESET_VECTOR;
		if (offset < 4 * PROG_WORDS) begin
			return prog[offset[9:2]];
		end
		return 32'h0000_0013; // ADDI x0, x0, 0
	endfunction

	task automatic gen_program();
		int    i;
		int    kind;
		int    rd;
		int    rs1;
		int    rs2;
		int    f3;
		int    skip;
		int    imm;
		int    max_tgt;
		word_t addr;
		i = 0;
		max_tgt = 0; // Furthest jump target so far
		while (i < BODY_WORDS) begin
			kind = $urandom_range(9, 0);
			rd = $urandom_range(31, 1);
			rs1 = $urandom_range(31, 0);
			rs2 = $urandom_range(1, 0) ? rs1 : $urandom_range(31, 0); // Equal operands often
			f3 = $urandom_range(7, 0);
			skip = $urandom_range(4, 1);
			imm = $urandom();
			if (i >= BODY_WORDS - 8 && kind >= 7) begin
				kind = 3; // No jumps close to the final stores
			end
			case (kind)
				0, 1, 2: prog[i] = enc_r((f3 == 0 || f3 == 5) && imm[0] ? 32 : 0, rs2, rs1, f3, rd);
				3: begin
					if (f3 == 1 || f3 == 5) begin
						imm = (f3 == 5 && imm[11]) ? 'h400 | (imm & 31) : imm & 31;
					end
					prog[i] = enc_i(imm, rs1, f3, rd, OPC_OP_IMM);
				end
				4: prog[i] = enc_u(imm, rd, imm[31] ? OPC_LUI : OPC_AUIPC);
				5: prog[i] = enc_s(4 * $urandom_range(63, 0), rs2, 0);
				6: prog[i] = enc_i(4 * $urandom_range(63, 0), 0, 2, rd, OPC_LOAD);
				7: begin
					f3 = (f3 == 2 || f3 == 3) ? f3 + 2 : f3; // Only the six branch codes
					prog[i] = enc_b(4 * (skip + 1), rs2, rs1, f3);
					max_tgt = (i + 1 + skip > max_tgt) ? i + 1 + skip : max_tgt;
				end
				8: begin
					prog[i] = enc_j(4 * (skip + 1), rs1);
					max_tgt = (i + 1 + skip > max_tgt) ? i + 1 + skip : max_tgt;
				end
				default: begin
					if (max_tgt <= i) begin
						// LUI and ADDI build the address and JALR adds a few stray low bits
						addr = RESET_VECTOR + 4 * (i + 3 + skip);
						prog[i] = enc_u(int'((addr + 32'h800) >> 12), rd, OPC_LUI);
						prog[i + 1] = enc_i(int'(addr[11:0]), rd, 0, rd, OPC_OP_IMM);
						prog[i + 2] = enc_i(imm & 3, rd, 0, rs1, OPC_JALR);
						max_tgt = i + 3 + skip;
						i += 2;
					end else begin
						prog[i] = enc_i(imm, rs1, 0, rd, OPC_OP_IMM);
					end
				end
			endcase
			i++;
		end
		for (int r = 1; r < 32; r++) begin
			prog[BODY_WORDS + r - 1] = enc_s(4 * r, r, 0);
		end
		prog[PROG_WORDS - 1] = enc_j(0, 0); // Jump to itself
	endtask

	tb_clock u_clock (.clock, .reset);

	core_top #(.RESET_VECTOR (RESET_VECTOR)) UUT (
		.clock, .reset, .iaddr, .idata, .ivalid, .iready,
		.daddr, .dwdata, .drdata, .dwrite, .dvalid, .dready
	);

	tb_checker #(.RESET_VECTOR (RESET_VECTOR)) u_checker (.*);

	// All random draws come from this one process
	initial begin
		void'($urandom(36808));
		idata = 32'h0000_0013;
		drdata = '0;
		iready = 1'b0;
		dready = 1'b0;
		for (int k = 0; k < 64; k++) begin
			dmem[k] = (32'(k * 4) * 32'h0100_0101) ^ 32'hDA7A_0000;
		end
		gen_program();
		@(posedge clock);
		forever begin
			@(negedge clock);
			idata = fetch_word(iaddr);
			drdata = (dvalid && !dwrite) ? dmem[daddr[7:2]] : $urandom();
			iready = ($urandom_range(3, 0) != 0);
			dready = ($urandom_range(3, 0) != 0);
		end
	end

	always @(posedge clock) begin
		if (dvalid && dready && dwrite) begin
			dmem[daddr[7:2]] <= dwdata;
		end
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("Timeout: the program did not reach its final loop within %0d ns", TIMEOUT_NS);
		$display("Checks: %0d, errors: %0d", checks, errors + UUT.u_asserts.failures + 1);
		$display("Test FAILED");
		$finish;
	end

	initial begin : report
		wait (done);
		repeat (2) @(posedge clock);
		$display("Checks: %0d, errors: %0d", checks, errors + UUT.u_asserts.failures);
		if (errors + UUT.u_asserts.failures == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end
endmodule

// File: project.f
design/isa_pkg.sv
design/core_pkg.sv
design/core_ifs.sv
design/core_regfile.sv
design/core_decode.sv
design/core_execute.sv
design/core_sequencer.sv
design/core_top.sv
testbench/tb_clock.sv
testbench/tb_checker.sv
testbench/core_asserts.sv
testbench/tb_top.sv

// File: Bender.yml
package:
  name: rv32i_multicycle_core

sources:
  - design/isa_pkg.sv
  - design/core_pkg.sv
  - design/core_ifs.sv
  - design/core_regfile.sv
  - design/core_decode.sv
  - design/core_execute.sv
  - design/core_sequencer.sv
  - design/core_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/tb_checker.sv
      - testbench/core_asserts.sv
      - testbench/tb_top.sv
